// File: common/freq_sel_pkg.sv
package freq_sel_pkg;

    // AXI4-Lite bus geometry
    localparam int AXI_DATA_W = 32;
    localparam int AXI_ADDR_W = 5;
    localparam int ADDR_LSB   = 2;

    typedef logic [AXI_DATA_W-1:0]   axi_data_t;
    typedef logic [AXI_ADDR_W-1:0]   axi_addr_t;
    typedef logic [AXI_DATA_W/8-1:0] axi_strb_t;
    typedef logic [2:0]              reg_sel_t;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // register map, word offsets
    localparam reg_sel_t REG_INDEX    = 3'd0;
    localparam reg_sel_t REG_RR_ADDR  = 3'd1;
    localparam reg_sel_t REG_RR_DATA  = 3'd2;
    localparam reg_sel_t REG_COUNT    = 3'd3;
    localparam reg_sel_t REG_STATUS   = 3'd4;
    localparam reg_sel_t REG_SCRATCH0 = 3'd5;
    localparam reg_sel_t REG_SCRATCH1 = 3'd6;
    localparam reg_sel_t REG_SCRATCH2 = 3'd7;

    // status register bits
    localparam int STAT_SOFT_RESET_BIT = 0;
    localparam int STAT_READY_BIT      = 2;

    // second frequency field inside an entry word
    localparam int FREQ_SECOND_LSB = 16;

    localparam int RING_DEPTH = 128;
    typedef logic [$clog2(RING_DEPTH)-1:0] ring_index_t;
    typedef logic [$clog2(RING_DEPTH):0]   ring_count_t;
    typedef logic [13:0]                   freq_first_t;
    typedef logic [3:0]                    freq_second_t;

    // random read busy window
    localparam int RR_LATENCY = 2;
    localparam int RR_CNT_W   = $clog2(RR_LATENCY + 1);

endpackage

// File: common/reg_bus_if.sv
`timescale 1ns/100ps

interface reg_bus_if import freq_sel_pkg::*; ();

    // write strobe side
    logic      wr_pulse;
    reg_sel_t  wr_sel;
    axi_data_t wr_data;
    axi_strb_t wr_strb;

    // register contents
    logic             busy;
    axi_data_t        index_reg;
    axi_data_t        rr_addr_reg;
    axi_data_t        rr_data;
    ring_count_t      count;
    logic             ready;
    axi_data_t [2:0]  scratch;

    modport decode (
        output wr_pulse, wr_sel, wr_data, wr_strb,
        input  busy
    );

    modport execute (
        input  wr_pulse, wr_sel, wr_data, wr_strb,
        output busy, index_reg, rr_addr_reg, rr_data, count, ready, scratch
    );

    modport result (
        input busy, index_reg, rr_addr_reg, rr_data, count, ready, scratch
    );

endinterface

// File: ring_store/ring_store.sv
`timescale 1ns/100ps

module ring_store import freq_sel_pkg::*; #(
    parameter int WIDTH = $bits(freq_first_t)
) (
    input  logic             clk,
    // active low, synchronous
    input  logic             rst,
    input  logic             clear,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             step,
    output ring_index_t      index,
    output logic [WIDTH-1:0] data,
    input  ring_index_t      rand_addr,
    output logic [WIDTH-1:0] rand_data,
    output ring_count_t      count
);

    logic [WIDTH-1:0] mem [RING_DEPTH];
    ring_count_t      index_inc;
    logic             full;
    logic             do_push;

    assign full      = (count == ring_count_t'(RING_DEPTH));
    assign do_push   = push && !full && !clear;
    assign index_inc = ring_count_t'(index) + 1'b1;

    // append at the tail, writes to a full ring are dropped
    always_ff @(posedge clk) begin
        if (do_push)
            mem[ring_index_t'(count)] <= push_data;
        rand_data <= mem[rand_addr];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
            index <= '0;
        end else if (clear) begin
            count <= '0;
            index <= '0;
        end else begin
            if (do_push)
                count <= count + 1'b1;
            // step wraps at the current fill level, empty ring stays put
            if (step && (count != '0)) begin
                if (index_inc == count)
                    index <= '0;
                else
                    index <= ring_index_t'(index_inc);
            end
        end
    end

    // current entry follows the index directly
    assign data = mem[index];

endmodule

// File: ring_store/ring_control.sv
`timescale 1ns/100ps

module ring_control import freq_sel_pkg::*; (
    input  logic         S_AXI_ACLK,
    input  logic         S_AXI_ARESETN,
    reg_bus_if.execute   bus,
    input  logic         rd_en_first,
    input  logic         rd_en_second,
    output ring_index_t  index_first,
    output ring_index_t  index_second,
    output freq_first_t  freq_first,
    output freq_second_t freq_second
);

    logic [RR_CNT_W-1:0] rr_cnt;
    axi_data_t           index_next;
    axi_data_t           rr_word;
    logic                push;
    logic                rr_start;
    logic                ring_clear;
    ring_index_t         rr_addr;
    freq_first_t         rand_first;
    freq_second_t        rand_second;

    // byte lanes with a set strobe take the new data
    function automatic axi_data_t merge_bytes(input axi_data_t old_word,
                                              input axi_data_t new_word,
                                              input axi_strb_t strb);
        axi_data_t merged;
        merged = old_word;
        for (int i = 0; i < $bits(axi_strb_t); i++) begin
            if (strb[i])
                merged[8*i +: 8] = new_word[8*i +: 8];
        end
        return merged;
    endfunction

    assign index_next = merge_bytes(bus.index_reg, bus.wr_data, bus.wr_strb);
    assign push       = bus.wr_pulse && (bus.wr_sel == REG_INDEX);
    assign rr_start   = bus.wr_pulse && (bus.wr_sel == REG_RR_ADDR);
    assign ring_clear = bus.wr_pulse && (bus.wr_sel == REG_STATUS)
                        && bus.wr_strb[STAT_SOFT_RESET_BIT / 8]
                        && bus.wr_data[STAT_SOFT_RESET_BIT];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            bus.index_reg   <= '0;
            bus.rr_addr_reg <= '0;
            bus.scratch     <= '0;
        end else if (bus.wr_pulse) begin
            case (bus.wr_sel)
                REG_INDEX:    bus.index_reg <= index_next;
                REG_RR_ADDR:  bus.rr_addr_reg <=
                                  merge_bytes(bus.rr_addr_reg, bus.wr_data, bus.wr_strb);
                REG_SCRATCH0: bus.scratch[0] <=
                                  merge_bytes(bus.scratch[0], bus.wr_data, bus.wr_strb);
                REG_SCRATCH1: bus.scratch[1] <=
                                  merge_bytes(bus.scratch[1], bus.wr_data, bus.wr_strb);
                REG_SCRATCH2: bus.scratch[2] <=
                                  merge_bytes(bus.scratch[2], bus.wr_data, bus.wr_strb);
                default: ;
            endcase
        end
    end

    // random read: address settles, memory registers, then capture
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rr_cnt      <= '0;
            bus.rr_data <= '0;
        end else begin
            if (rr_start)
                rr_cnt <= RR_CNT_W'(RR_LATENCY);
            else if (rr_cnt != '0)
                rr_cnt <= rr_cnt - 1'b1;
            if (rr_cnt == RR_CNT_W'(1))
                bus.rr_data <= rr_word;
        end
    end

    always_comb begin
        rr_word = '0;
        rr_word[$bits(freq_first_t)-1:0] = rand_first;
        rr_word[FREQ_SECOND_LSB +: $bits(freq_second_t)] = rand_second;
    end

    assign rr_addr  = bus.rr_addr_reg[$bits(ring_index_t)-1:0];
    assign bus.busy = (rr_cnt != '0);

    // both rings take every push, so the first ring's count stands for both
    assign bus.ready = (bus.count != '0);

    ring_store #(
        .WIDTH ($bits(freq_first_t))
    ) u_ring_first (
        .clk       (S_AXI_ACLK),
        .rst       (S_AXI_ARESETN),
        .clear     (ring_clear),
        .push      (push),
        .push_data (index_next[$bits(freq_first_t)-1:0]),
        .step      (rd_en_first),
        .index     (index_first),
        .data      (freq_first),
        .rand_addr (rr_addr),
        .rand_data (rand_first),
        .count     (bus.count)
    );

    ring_store #(
        .WIDTH ($bits(freq_second_t))
    ) u_ring_second (
        .clk       (S_AXI_ACLK),
        .rst       (S_AXI_ARESETN),
        .clear     (ring_clear),
        .push      (push),
        .push_data (index_next[FREQ_SECOND_LSB +: $bits(freq_second_t)]),
        .step      (rd_en_second),
        .index     (index_second),
        .data      (freq_second),
        .rand_addr (rr_addr),
        .rand_data (rand_second),
        .count     ()
    );

endmodule

// File: hw/axi_write_decode.sv
`timescale 1ns/100ps

module axi_write_decode import freq_sel_pkg::*; (
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,

    input  axi_addr_t  s_axi_awaddr,
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    input  axi_data_t  s_axi_wdata,
    input  axi_strb_t  s_axi_wstrb,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,
    output logic [1:0] s_axi_bresp,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,

    reg_bus_if.decode  bus
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_ACCEPT,
        W_RESP
    } wr_state_t;

    wr_state_t state;
    axi_addr_t awaddr_q;
    logic      start;
    logic      handshake;

    // address and data both present, ring logic idle, no response pending
    assign start = (state == W_IDLE) && s_axi_awvalid && s_axi_wvalid && !bus.busy;

    assign handshake = (state == W_ACCEPT) && s_axi_awvalid && s_axi_wvalid;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: begin
                    if (start)
                        state <= W_ACCEPT;
                end
                W_ACCEPT: begin
                    if (handshake)
                        state <= W_RESP;
                end
                W_RESP: begin
                    // response held until the master takes it
                    if (s_axi_bready)
                        state <= W_IDLE;
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

    // both ready lines pulse together for the single accept cycle
    assign s_axi_awready = (state == W_ACCEPT);
    assign s_axi_wready  = (state == W_ACCEPT);
    assign s_axi_bvalid  = (state == W_RESP);
    assign s_axi_bresp   = RESP_OKAY;

    // strobe lines up with the first response cycle
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            bus.wr_pulse <= 1'b0;
        end else begin
            bus.wr_pulse <= handshake;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (start) begin
            awaddr_q <= s_axi_awaddr;
        end
        if (handshake) begin
            bus.wr_data <= s_axi_wdata;
            bus.wr_strb <= s_axi_wstrb;
        end
    end

    // word address picks the register
    assign bus.wr_sel = awaddr_q[ADDR_LSB +: $bits(reg_sel_t)];

endmodule

// File: hw/axi_read_result.sv
`timescale 1ns/100ps

module axi_read_result import freq_sel_pkg::*; (
    input  logic       S_AXI_ACLK,
    input  logic       S_AXI_ARESETN,

    input  axi_addr_t  s_axi_araddr,
    input  logic       s_axi_arvalid,
    output logic       s_axi_arready,
    output axi_data_t  s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic       s_axi_rvalid,
    input  logic       s_axi_rready,

    reg_bus_if.result  bus
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } rd_state_t;

    rd_state_t state;
    axi_addr_t araddr_q;
    axi_data_t reg_word;
    logic      start;

    // no new address while a random read is in flight or data is pending
    assign start = (state == R_IDLE) && s_axi_arvalid && !bus.busy;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= R_IDLE;
        end else begin
            case (state)
                R_IDLE: begin
                    if (start)
                        state <= R_ADDR;
                end
                R_ADDR: begin
                    if (s_axi_arvalid)
                        state <= R_DATA;
                end
                R_DATA: begin
                    if (s_axi_rready)
                        state <= R_IDLE;
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        reg_word = '0;
        case (araddr_q[ADDR_LSB +: $bits(reg_sel_t)])
            REG_INDEX:    reg_word = bus.index_reg;
            REG_RR_ADDR:  reg_word = bus.rr_addr_reg;
            REG_RR_DATA:  reg_word = bus.rr_data;
            REG_COUNT:    reg_word = axi_data_t'(bus.count);
            // only the ready flag reads back
            REG_STATUS:   reg_word[STAT_READY_BIT] = bus.ready;
            REG_SCRATCH0: reg_word = bus.scratch[0];
            REG_SCRATCH1: reg_word = bus.scratch[1];
            REG_SCRATCH2: reg_word = bus.scratch[2];
            default:      reg_word = '0;
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (start) begin
            araddr_q <= s_axi_araddr;
        end
        if ((state == R_ADDR) && s_axi_arvalid) begin
            s_axi_rdata <= reg_word;
        end
    end

    assign s_axi_arready = (state == R_ADDR);
    assign s_axi_rvalid  = (state == R_DATA);
    assign s_axi_rresp   = RESP_OKAY;

endmodule

// File: hw/freq_selector_top.sv
`timescale 1ns/100ps

module freq_selector_top import freq_sel_pkg::*; (
    input  logic         S_AXI_ACLK,
    input  logic         S_AXI_ARESETN,

    // write address, data and response channels
    input  axi_addr_t    s_axi_awaddr,
    input  logic         s_axi_awvalid,
    output logic         s_axi_awready,
    input  axi_data_t    s_axi_wdata,
    input  axi_strb_t    s_axi_wstrb,
    input  logic         s_axi_wvalid,
    output logic         s_axi_wready,
    output logic [1:0]   s_axi_bresp,
    output logic         s_axi_bvalid,
    input  logic         s_axi_bready,

    // read address and data channels
    input  axi_addr_t    s_axi_araddr,
    input  logic         s_axi_arvalid,
    output logic         s_axi_arready,
    output axi_data_t    s_axi_rdata,
    output logic [1:0]   s_axi_rresp,
    output logic         s_axi_rvalid,
    input  logic         s_axi_rready,

    // ring stepping and current entries
    input  logic         rd_en_first,
    input  logic         rd_en_second,
    output ring_index_t  index_first,
    output ring_index_t  index_second,
    output freq_first_t  freq_first,
    output freq_second_t freq_second
);

    reg_bus_if bus ();

    axi_write_decode u_write_decode (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .bus           (bus.decode)
    );

    ring_control u_ring_control (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .bus           (bus.execute),
        .rd_en_first   (rd_en_first),
        .rd_en_second  (rd_en_second),
        .index_first   (index_first),
        .index_second  (index_second),
        .freq_first    (freq_first),
        .freq_second   (freq_second)
    );

    axi_read_result u_read_result (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .bus           (bus.result)
    );

endmodule

// File: bench/freq_selector_assertions.sv
`timescale 1ns/100ps

module freq_selector_assertions (
    input logic clk,
    input logic resetn,
    input logic resp_valid,
    input logic resp_ready,
    input logic addr_ready,
    input logic busy
);

    int fail_count = 0;

    // response stays up until the master takes it
    resp_held_check: assert property (@(posedge clk) disable iff (!resetn)
        resp_valid && !resp_ready |=> resp_valid)
        else begin
            fail_count++;
            $error("response valid dropped before the ready was seen");
        end

    // address acceptance never starts during a random read
    accept_idle_check: assert property (@(posedge clk) disable iff (!resetn)
        $rose(addr_ready) |-> !busy)
        else begin
            fail_count++;
            $error("address ready rose while the random read was busy");
        end

endmodule

bind axi_write_decode freq_selector_assertions write_checks (
    .clk        (S_AXI_ACLK),
    .resetn     (S_AXI_ARESETN),
    .resp_valid (s_axi_bvalid),
    .resp_ready (s_axi_bready),
    .addr_ready (s_axi_awready),
    .busy       (bus.busy)
);

bind axi_read_result freq_selector_assertions read_checks (
    .clk        (S_AXI_ACLK),
    .resetn     (S_AXI_ARESETN),
    .resp_valid (s_axi_rvalid),
    .resp_ready (s_axi_rready),
    .addr_ready (s_axi_arready),
    .busy       (bus.busy)
);

// File: bench/freq_selector_tb.sv
`timescale 1ns/100ps

module freq_selector_tb import freq_sel_pkg::*; ();

    localparam int MAX_CMDS       = 64;
    localparam int CYCLES_PER_CMD = 40;

    logic         S_AXI_ACLK;
    logic         S_AXI_ARESETN;
    axi_addr_t    awaddr;
    logic         awvalid;
    logic         awready;
    axi_data_t    wdata;
    axi_strb_t    wstrb;
    logic         wvalid;
    logic         wready;
    logic [1:0]   bresp;
    logic         bvalid;
    logic         bready;
    axi_addr_t    araddr;
    logic         arvalid;
    logic         arready;
    axi_data_t    rdata;
    logic [1:0]   rresp;
    logic         rvalid;
    logic         rready;
    logic         rd_en_first;
    logic         rd_en_second;
    ring_index_t  index_first;
    ring_index_t  index_second;
    freq_first_t  freq_first;
    freq_second_t freq_second;

    // command table loaded from the data file
    logic [8*16-1:0] test_name [MAX_CMDS];
    logic [7:0]      cmd_code  [MAX_CMDS];
    axi_data_t       cmd_arg   [MAX_CMDS][3];
    int              num_cmds       = 0;
    int              budget_cycles  = 0;
    int              mismatch_count = 0;
    int              other_count    = 0;
    int              assert_count   = 0;
    int              seed           = 85;
    logic            stall_mode     = 1'b0;
    axi_data_t       got;
    axi_data_t       got_index;
    axi_data_t       got_freq;

    freq_selector_top uut (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (awaddr),
        .s_axi_awvalid (awvalid),
        .s_axi_awready (awready),
        .s_axi_wdata   (wdata),
        .s_axi_wstrb   (wstrb),
        .s_axi_wvalid  (wvalid),
        .s_axi_wready  (wready),
        .s_axi_bresp   (bresp),
        .s_axi_bvalid  (bvalid),
        .s_axi_bready  (bready),
        .s_axi_araddr  (araddr),
        .s_axi_arvalid (arvalid),
        .s_axi_arready (arready),
        .s_axi_rdata   (rdata),
        .s_axi_rresp   (rresp),
        .s_axi_rvalid  (rvalid),
        .s_axi_rready  (rready),
        .rd_en_first   (rd_en_first),
        .rd_en_second  (rd_en_second),
        .index_first   (index_first),
        .index_second  (index_second),
        .freq_first    (freq_first),
        .freq_second   (freq_second)
    );

    initial S_AXI_ACLK = 1'b0;
    always #10 S_AXI_ACLK = ~S_AXI_ACLK;

    function automatic int arg_count(input logic [7:0] cmd);
        case (cmd)
            "W", "S": return 3;
            "R", "P": return 2;
            "A":      return 1;
            default:  return 0;
        endcase
    endfunction

    // always ready unless stalls are on, then a coin toss
    function automatic logic choose_ready();
        int r;
        if (!stall_mode)
            return 1'b1;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic load_commands();
        int              fd;
        int              code;
        int              ch;
        logic [8*16-1:0] word;
        fd = $fopen("bench/freq_selector_input.txt", "r");
        if (fd == 0) begin
            other_count++;
            $display("could not open bench/freq_selector_input.txt");
            return;
        end
        while ($fscanf(fd, "%s", word) == 1) begin
            if (word == {120'd0, "#"}) begin
                // comment line, drop the rest
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);
            end else if (num_cmds < MAX_CMDS) begin
                test_name[num_cmds] = word;
                code = $fscanf(fd, "%s", cmd_code[num_cmds]);
                for (int i = 0; i < arg_count(cmd_code[num_cmds]); i++)
                    code = $fscanf(fd, "%h", cmd_arg[num_cmds][i]);
                num_cmds++;
            end else begin
                other_count++;
                $display("too many commands in the stimulus file");
                break;
            end
        end
        $fclose(fd);
    endtask

    // AXI response code OKAY is all zeros
    task automatic axi_write(input logic [8*16-1:0] name, input axi_addr_t addr,
                             input axi_data_t data, input axi_strb_t strb);
        logic done;
        @(posedge S_AXI_ACLK);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do
            @(negedge S_AXI_ACLK);
        while (!(awready && wready));
        done = 1'b0;
        while (!done) begin
            @(posedge S_AXI_ACLK);
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= choose_ready();
            @(negedge S_AXI_ACLK);
            done = bvalid && bready;
        end
        if (bresp !== 2'b00) begin
            mismatch_count++;
            $display("MISMATCH %0s bresp: expected %h, actual %h", name, 2'b00, bresp);
        end
        @(posedge S_AXI_ACLK);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [8*16-1:0] name, input axi_addr_t addr,
                            output axi_data_t data);
        logic done;
        @(posedge S_AXI_ACLK);
        araddr  <= addr;
        arvalid <= 1'b1;
        do
            @(negedge S_AXI_ACLK);
        while (!arready);
        done = 1'b0;
        while (!done) begin
            @(posedge S_AXI_ACLK);
            arvalid <= 1'b0;
            rready  <= choose_ready();
            @(negedge S_AXI_ACLK);
            done = rvalid && rready;
        end
        data = rdata;
        if (rresp !== 2'b00) begin
            mismatch_count++;
            $display("MISMATCH %0s rresp: expected %h, actual %h", name, 2'b00, rresp);
        end
        @(posedge S_AXI_ACLK);
        rready <= 1'b0;
    endtask

    // one rd_en pulse, outputs settle by the following falling edge
    task automatic step_ring(input logic second);
        @(posedge S_AXI_ACLK);
        if (second)
            rd_en_second <= 1'b1;
        else
            rd_en_first <= 1'b1;
        @(posedge S_AXI_ACLK);
        rd_en_first  <= 1'b0;
        rd_en_second <= 1'b0;
        @(negedge S_AXI_ACLK);
    endtask

    // entry k holds k in the second field and base + k in the first
    task automatic push_pattern(input logic [8*16-1:0] name, input axi_data_t entries,
                                input axi_data_t base);
        axi_data_t entry;
        for (int k = 0; k < int'(entries); k++) begin
            entry = ((axi_data_t'(k) & 32'hf) << FREQ_SECOND_LSB)
                    | ((base + axi_data_t'(k)) & 32'h3fff);
            axi_write(name, '0, entry, 4'hf);
        end
    endtask

    initial begin : watchdog
        wait (budget_cycles != 0);
        repeat (budget_cycles) @(posedge S_AXI_ACLK);
        $display("timeout: command sequence still running after %0d cycles", budget_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        S_AXI_ARESETN = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        rd_en_first   = 1'b0;
        rd_en_second  = 1'b0;
        load_commands();
        // 40 cycles per command, a fill costs that per entry
        budget_cycles = 100;
        for (int i = 0; i < num_cmds; i++)
            budget_cycles += (cmd_code[i] == "P") ? CYCLES_PER_CMD * int'(cmd_arg[i][0])
                                                  : CYCLES_PER_CMD;
        repeat (5) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;

        for (int n = 0; n < num_cmds; n++) begin
            case (cmd_code[n])
                "W": axi_write(test_name[n], axi_addr_t'(cmd_arg[n][0]), cmd_arg[n][1],
                               axi_strb_t'(cmd_arg[n][2]));
                "R": begin
                    axi_read(test_name[n], axi_addr_t'(cmd_arg[n][0]), got);
                    if (got !== cmd_arg[n][1]) begin
                        mismatch_count++;
                        $display("MISMATCH %0s: expected %h, actual %h",
                                 test_name[n], cmd_arg[n][1], got);
                    end
                end
                "S": begin
                    step_ring(cmd_arg[n][0][0]);
                    got_index = cmd_arg[n][0][0] ? axi_data_t'(index_second)
                                                 : axi_data_t'(index_first);
                    got_freq  = cmd_arg[n][0][0] ? axi_data_t'(freq_second)
                                                 : axi_data_t'(freq_first);
                    if (got_index !== cmd_arg[n][1]) begin
                        mismatch_count++;
                        $display("MISMATCH %0s index: expected %h, actual %h",
                                 test_name[n], cmd_arg[n][1], got_index);
                    end
                    if (got_freq !== cmd_arg[n][2]) begin
                        mismatch_count++;
                        $display("MISMATCH %0s freq: expected %h, actual %h",
                                 test_name[n], cmd_arg[n][2], got_freq);
                    end
                end
                "A": stall_mode = cmd_arg[n][0][0];
                "P": push_pattern(test_name[n], cmd_arg[n][0], cmd_arg[n][1]);
                default: begin
                    other_count++;
                    $display("unknown command in test %0s", test_name[n]);
                end
            endcase
        end

        assert_count = uut.u_write_decode.write_checks.fail_count
                       + uut.u_read_result.read_checks.fail_count;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, other_count, assert_count);
        if (mismatch_count == 0 && other_count == 0 && assert_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: freq_selector.f
common/freq_sel_pkg.sv
common/reg_bus_if.sv
ring_store/ring_store.sv
ring_store/ring_control.sv
hw/axi_write_decode.sv
hw/axi_read_result.sv
hw/freq_selector_top.sv
bench/freq_selector_assertions.sv
bench/freq_selector_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= freq_selector_tb
FILELIST   ?= freq_selector.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/freq_selector_input.txt
# columns: test name, command letter, then hex arguments
# W addr data strb | R addr expected | S ring index freq | A stall | P entries base
scr0_wr      W 14 a5a5a5a5 f
stall_on     A 1
scr0_rd      R 14 a5a5a5a5
scr1_wr      W 18 12345678 f
scr1_bytes   W 18 ffffffff 5
scr1_rd      R 18 12ff56ff
scr2_wr      W 1c 0badf00d f
scr2_byte1   W 1c 00001100 2
scr2_rd      R 1c 0bad110d
stall_off    A 0
empty_count  R 0c 00000000
empty_status R 10 00000000
push0        W 00 00032345 f
push1        W 00 000a1111 f
push2        W 00 000f3fff f
count3       R 0c 00000003
ready_set    R 10 00000004
index_rd     R 00 000f3fff
step_f1      S 0 01 1111
step_f2      S 0 02 3fff
step_f_wrap  S 0 00 2345
step_s1      S 1 01 000a
rr_addr2     W 04 00000002 f
rr_data2     R 08 000f3fff
rr_addr0     W 04 00000000 f
rr_data0     R 08 00032345
soft_reset   W 10 00000001 1
sr_count     R 0c 00000000
sr_status    R 10 00000000
sr_scratch0  R 14 a5a5a5a5
sr_step_f    S 0 00 2345
sr_step_s    S 1 00 0003
fill         P 82 00000100
full_count   R 0c 00000080
full_status  R 10 00000004
rr_addr45    W 04 00000045 f
rr_data45    R 08 00050145
rr_addr7f    W 04 0000007f f
rr_data7f    R 08 000f017f
